/* led_matrix_settings.svh */
`ifndef LED_MATRIX_SETTINGS_SVH
`define LED_MATRIX_SETTINGS_SVH

// panel geometry, one half of a 64x32 panel with 1/16 scan
`define LM_COLUMNS 64
`define LM_ROWS 16

// bit planes shown per row with binary coded modulation
`define LM_PLANES 5

// rising edges from pixel_load_start until top and bottom pixels are valid
// RAM has two cycles of read latency plus the half select setup
`define LM_FETCH_WAIT 5

// display cycles for plane 0
// plane p is shown for LM_OE_BASE << p cycles
`define LM_OE_BASE 8

`endif

/* led_matrix_pkg.sv */
`default_nettype none

`include "led_matrix_settings.svh"

package led_matrix_pkg;

	// index widths follow the panel geometry
	typedef logic [$clog2(`LM_COLUMNS)-1:0] column_t;
	typedef logic [$clog2(`LM_ROWS)-1:0] row_t;
	typedef logic [$clog2(`LM_PLANES)-1:0] plane_t;

	// framebuffer word address
	// bit 10 half select, 9..6 row, 5..0 inverted column
	typedef logic [$bits(row_t)+$bits(column_t):0] fb_addr_t;

	// red 15..11, green 10..5, blue 4..0
	typedef logic [15:0] rgb565_t;

	// one host write, address and pixel together
	typedef struct packed {
		fb_addr_t addr;
		rgb565_t data;
	} fb_write_t;

	// scan controller states
	typedef enum logic [2:0] {
		FETCH, SHIFT_LOW, SHIFT_HIGH, BLANK, LATCH, SHOW
	} scan_state_t;

endpackage

`default_nettype wire

/* countdown_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module countdown_timer #(
	parameter int COUNTER_WIDTH = 2
) (
	input wire reset,
	input wire clk_in,

	input wire start,
	input wire [COUNTER_WIDTH-1:0] value,

	output logic [COUNTER_WIDTH-1:0] counter,
	output logic running
);

	always_ff @(posedge clk_in) begin
		if (reset) begin
			counter <= '0;
			running <= 1'b0;
		end else if (start) begin
			// a start while busy simply reloads
			counter <= value;
			running <= 1'b1;
		end else if (running) begin
			// stop one edge after reaching zero
			if (counter == '0) begin
				running <= 1'b0;
			end else begin
				counter <= counter - 1'b1;
			end
		end
	end

	// counter parks at zero while idle

endmodule

`default_nettype wire

/* framebuffer_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module framebuffer_ram (
	input wire reset,
	input wire clk_in,

	// host write port, four phase req/ack
	input wire write_req,
	input led_matrix_pkg::fb_write_t write,
	output logic write_ack,

	// fetch read port
	input led_matrix_pkg::fb_addr_t ram_address,
	input wire ram_clk_enable,
	output led_matrix_pkg::rgb565_t ram_data
);

	import led_matrix_pkg::*;

	localparam int DEPTH = 2 ** $bits(fb_addr_t);

	rgb565_t mem [DEPTH];
	rgb565_t read_stage;
	logic write_fire;

	// power-up contents are black
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	// accept a request only while the previous ack has dropped
	assign write_fire = write_req & ~write_ack & ~reset;

	always_ff @(posedge clk_in) begin
		if (write_fire) begin
			mem[write.addr] <= write.data;
		end
	end

	// ack rises with the store and falls the edge after req drops
	always_ff @(posedge clk_in) begin
		if (reset) begin
			write_ack <= 1'b0;
		end else if (write_fire) begin
			write_ack <= 1'b1;
		end else if (!write_req) begin
			write_ack <= 1'b0;
		end
	end

	// two stage read, both stages frozen while the enable is low
	always_ff @(posedge clk_in) begin
		if (ram_clk_enable) begin
			read_stage <= mem[ram_address];
			ram_data <= read_stage;
		end
	end

endmodule

`default_nettype wire

/* framebuffer_fetch.sv */
`timescale 1ns/1ns
`default_nettype none

module framebuffer_fetch (
	input wire reset,
	input wire clk_in,

	// pixel position requested by the scan controller
	input led_matrix_pkg::column_t column_address,
	input led_matrix_pkg::row_t row_address,

	// one cycle pulse, starts a top and bottom read
	input wire pixel_load_start,

	// RAM read port
	input led_matrix_pkg::rgb565_t ram_data,
	output led_matrix_pkg::fb_addr_t ram_address,
	output logic ram_clk_enable,

	// both halves of the current column
	output led_matrix_pkg::rgb565_t rgb565_top,
	output led_matrix_pkg::rgb565_t rgb565_bottom
);

	import led_matrix_pkg::*;

	logic [1:0] load_count;
	logic half_address;

	// columns are stored reversed so column 63 sits at the lowest address
	assign ram_address = {half_address, row_address, ~column_address};

	// sequence counter 3,2,1,0 after the start pulse
	// the RAM only clocks while this runs
	countdown_timer #(
		.COUNTER_WIDTH(2)
	) u_load_timer (
		.reset(reset),
		.clk_in(clk_in),
		.start(pixel_load_start),
		.value(2'd3),
		.counter(load_count),
		.running(ram_clk_enable)
	);

	// half select moves on the falling edge
	// so the address is settled before the next RAM edge
	always_ff @(negedge clk_in) begin
		if (reset) begin
			half_address <= 1'b0;
		end else if (load_count == 2'd3) begin
			// top half read first
			half_address <= 1'b0;
		end else if (load_count == 2'd2) begin
			half_address <= 1'b1;
		end
	end

	// capture mid cycle, data is two enabled edges behind its address
	always_ff @(negedge clk_in) begin
		if (load_count == 2'd1) begin
			rgb565_top <= ram_data;
		end else if (load_count == 2'd0) begin
			// repeats while idle, RAM output is frozen then
			rgb565_bottom <= ram_data;
		end
	end

endmodule

`default_nettype wire

/* matrix_scan.sv */
`timescale 1ns/1ns
`default_nettype none

`include "led_matrix_settings.svh"

module matrix_scan (
	input wire reset,
	input wire clk_in,

	// pixels from the fetch block, valid LM_FETCH_WAIT edges after start
	input led_matrix_pkg::rgb565_t rgb565_top,
	input led_matrix_pkg::rgb565_t rgb565_bottom,

	// fetch request
	output led_matrix_pkg::column_t column_address,
	output led_matrix_pkg::row_t row_address,
	output logic pixel_load_start,

	// HUB75 panel signals
	output logic panel_clk,
	output logic panel_latch,
	output logic panel_oe,
	output led_matrix_pkg::row_t panel_row,
	output logic [2:0] rgb1,
	output logic [2:0] rgb2
);

	import led_matrix_pkg::*;

	localparam int WAIT_WIDTH = $clog2(`LM_FETCH_WAIT);
	// wide enough for the longest plane
	localparam int SHOW_WIDTH = $clog2(`LM_OE_BASE << (`LM_PLANES - 1)) + 1;

	localparam column_t LAST_COLUMN = column_t'(`LM_COLUMNS - 1);
	localparam row_t LAST_ROW = row_t'(`LM_ROWS - 1);
	localparam plane_t LAST_PLANE = plane_t'(`LM_PLANES - 1);

	scan_state_t state;
	plane_t plane;
	logic [WAIT_WIDTH-1:0] wait_count;
	logic [SHOW_WIDTH-1:0] show_count;

	// pick one plane out of an RGB565 pixel
	// result is {red, green, blue}
	// green has one more bit, so its plane sits one bit higher
	function automatic logic [2:0] plane_bits(input rgb565_t pixel, input plane_t sel);
		logic red_bit;
		logic green_bit;
		logic blue_bit;
		red_bit = pixel[11 + sel];
		green_bit = pixel[6 + sel];
		blue_bit = pixel[sel];
		return {red_bit, green_bit, blue_bit};
	endfunction

	always_ff @(posedge clk_in) begin
		if (reset) begin
			state <= FETCH;
			column_address <= LAST_COLUMN;
			row_address <= '0;
			plane <= '0;
			wait_count <= '0;
			show_count <= '0;
			// first fetch kicks off as reset releases
			pixel_load_start <= 1'b1;
			panel_clk <= 1'b0;
			panel_latch <= 1'b0;
			panel_oe <= 1'b1;
			panel_row <= '0;
			rgb1 <= '0;
			rgb2 <= '0;
		end else begin
			// start is a single cycle pulse
			pixel_load_start <= 1'b0;

			case (state)
				FETCH: begin
					// wait out the fixed fetch latency
					if (wait_count == WAIT_WIDTH'(`LM_FETCH_WAIT - 1)) begin
						// present data with the shift clock low
						rgb1 <= plane_bits(rgb565_top, plane);
						rgb2 <= plane_bits(rgb565_bottom, plane);
						state <= SHIFT_LOW;
					end else begin
						wait_count <= wait_count + 1'b1;
					end
				end

				SHIFT_LOW: begin
					// panel samples on this rising edge
					panel_clk <= 1'b1;
					state <= SHIFT_HIGH;
				end

				SHIFT_HIGH: begin
					panel_clk <= 1'b0;
					wait_count <= '0;
					if (column_address == '0) begin
						// whole row shifted
						// blank and move the row lines while dark
						panel_row <= row_address;
						state <= BLANK;
					end else begin
						// columns go out from 63 down to 0
						column_address <= column_address - 1'b1;
						pixel_load_start <= 1'b1;
						state <= FETCH;
					end
				end

				BLANK: begin
					panel_latch <= 1'b1;
					state <= LATCH;
				end

				LATCH: begin
					panel_latch <= 1'b0;
					panel_oe <= 1'b0;
					// display time doubles with each plane
					show_count <= SHOW_WIDTH'((`LM_OE_BASE << plane) - 1);
					state <= SHOW;
				end

				SHOW: begin
					if (show_count == '0) begin
						panel_oe <= 1'b1;
						// next plane, or next row after the last plane
						if (plane == LAST_PLANE) begin
							plane <= '0;
							if (row_address == LAST_ROW) begin
								row_address <= '0;
							end else begin
								row_address <= row_address + 1'b1;
							end
						end else begin
							plane <= plane + 1'b1;
						end
						column_address <= LAST_COLUMN;
						pixel_load_start <= 1'b1;
						state <= FETCH;
					end else begin
						show_count <= show_count - 1'b1;
					end
				end

				default: begin
					// unreachable encodings fall back to a safe dark state
					panel_oe <= 1'b1;
					panel_clk <= 1'b0;
					panel_latch <= 1'b0;
					wait_count <= '0;
					column_address <= LAST_COLUMN;
					pixel_load_start <= 1'b1;
					state <= FETCH;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* led_matrix_top.sv */
`timescale 1ns/1ns
`default_nettype none

module led_matrix_top (
	input wire reset,
	input wire clk_in,

	// host pixel writes
	input wire write_req,
	input led_matrix_pkg::fb_write_t write,
	output logic write_ack,

	// HUB75 panel
	output logic panel_clk,
	output logic panel_latch,
	output logic panel_oe,
	output led_matrix_pkg::row_t panel_row,
	output logic [2:0] rgb1,
	output logic [2:0] rgb2
);

	import led_matrix_pkg::*;

	// fetch to RAM
	fb_addr_t ram_address;
	logic ram_clk_enable;
	rgb565_t ram_data;

	// scan to fetch
	column_t column_address;
	row_t row_address;
	logic pixel_load_start;
	rgb565_t rgb565_top;
	rgb565_t rgb565_bottom;

	framebuffer_ram u_framebuffer_ram (
		.reset(reset),
		.clk_in(clk_in),
		.write_req(write_req),
		.write(write),
		.write_ack(write_ack),
		.ram_address(ram_address),
		.ram_clk_enable(ram_clk_enable),
		.ram_data(ram_data)
	);

	framebuffer_fetch u_framebuffer_fetch (
		.reset(reset),
		.clk_in(clk_in),
		.column_address(column_address),
		.row_address(row_address),
		.pixel_load_start(pixel_load_start),
		.ram_data(ram_data),
		.ram_address(ram_address),
		.ram_clk_enable(ram_clk_enable),
		.rgb565_top(rgb565_top),
		.rgb565_bottom(rgb565_bottom)
	);

	// fixed fetch latency so no handshake back from the fetch block
	matrix_scan u_matrix_scan (
		.reset(reset),
		.clk_in(clk_in),
		.rgb565_top(rgb565_top),
		.rgb565_bottom(rgb565_bottom),
		.column_address(column_address),
		.row_address(row_address),
		.pixel_load_start(pixel_load_start),
		.panel_clk(panel_clk),
		.panel_latch(panel_latch),
		.panel_oe(panel_oe),
		.panel_row(panel_row),
		.rgb1(rgb1),
		.rgb2(rgb2)
	);

endmodule

`default_nettype wire

/* tb_led_matrix.sv */
`timescale 1ns/1ns
`default_nettype none

`include "led_matrix_settings.svh"

module tb_led_matrix;

	import led_matrix_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int WRITE_COUNT = 200;
	localparam int ACK_TIMEOUT = 20;
	localparam int FB_WORDS = 2 * `LM_ROWS * `LM_COLUMNS;
	// FETCH plus SHIFT_LOW plus SHIFT_HIGH
	localparam int COLUMN_PERIOD = `LM_FETCH_WAIT + 2;
	localparam int FRAMES_USED = 6;
	localparam int MARGIN_CYCLES = 4000;

	logic clk_in;
	logic reset;
	logic write_req;
	fb_write_t write;
	logic write_ack;
	logic panel_clk;
	logic panel_latch;
	logic panel_oe;
	row_t panel_row;
	logic [2:0] rgb1;
	logic [2:0] rgb2;

	// framebuffer mirror, indexed by word address
	rgb565_t model [FB_WORDS];

	integer seed;
	int err_reset;
	int err_handshake;
	int err_content;
	int err_order;
	int err_timing;
	int err_live;
	int tests_run;
	int tests_failed;
	bit compare_en;
	bit live_phase;
	int frame_count;

	// panel receiver state
	logic [`LM_COLUMNS-1:0] red1;
	logic [`LM_COLUMNS-1:0] green1;
	logic [`LM_COLUMNS-1:0] blue1;
	logic [`LM_COLUMNS-1:0] red2;
	logic [`LM_COLUMNS-1:0] green2;
	logic [`LM_COLUMNS-1:0] blue2;
	int shift_count;
	int clk_gap;
	int oe_cycles;
	int exp_row;
	int exp_plane;
	int shown_plane;
	logic prev_clk;
	logic prev_latch;
	logic prev_oe;
	logic prev_req;
	logic prev_ack;
	row_t prev_row;

	led_matrix_top u_led_matrix_top (
		.reset(reset),
		.clk_in(clk_in),
		.write_req(write_req),
		.write(write),
		.write_ack(write_ack),
		.panel_clk(panel_clk),
		.panel_latch(panel_latch),
		.panel_oe(panel_oe),
		.panel_row(panel_row),
		.rgb1(rgb1),
		.rgb2(rgb2)
	);

	always #(CLK_PERIOD / 2) clk_in = ~clk_in;

	// cycles per frame, from the scan timing rules
	function automatic longint frame_cycles();
		longint row_len;
		int p;
		row_len = 0;
		for (p = 0; p < `LM_PLANES; p++) begin
			// shift, blank, latch, then the display interval
			row_len += `LM_COLUMNS * COLUMN_PERIOD + 2 + (`LM_OE_BASE << p);
		end
		return row_len * `LM_ROWS;
	endfunction

	// {red, green, blue} of one plane for a panel position
	function automatic logic [2:0] expected_bits(input int half, input int row,
			input int column, input int plane);
		rgb565_t pixel;
		logic [4:0] red;
		logic [5:0] green;
		logic [4:0] blue;
		// columns sit reversed within each stored row
		pixel = model[half * `LM_ROWS * `LM_COLUMNS + row * `LM_COLUMNS
			+ (`LM_COLUMNS - 1 - column)];
		red = pixel[15:11];
		green = pixel[10:5];
		blue = pixel[4:0];
		// green carries one extra bit
		return {red[plane], green[plane + 1], blue[plane]};
	endfunction

	task automatic note_content_error();
		if (live_phase) begin
			err_live++;
		end else begin
			err_content++;
		end
	endtask

	// compare shifted row at a latch, then step row and plane
	task automatic latch_row();
		logic [2:0] got_top;
		logic [2:0] got_bottom;
		logic [2:0] want_top;
		logic [2:0] want_bottom;
		int c;
		assert (shift_count == `LM_COLUMNS) else begin
			$display("CHECK FAILED shift_count: got %h expected %h", shift_count, `LM_COLUMNS);
			note_content_error();
		end
		assert (panel_row == row_t'(exp_row)) else begin
			$display("CHECK FAILED panel_row: got %h expected %h", panel_row, exp_row);
			err_order++;
		end
		if (compare_en) begin
			for (c = 0; c < `LM_COLUMNS; c++) begin
				// shift register bit c holds column c
				got_top = {red1[c], green1[c], blue1[c]};
				got_bottom = {red2[c], green2[c], blue2[c]};
				want_top = expected_bits(0, exp_row, c, exp_plane);
				want_bottom = expected_bits(1, exp_row, c, exp_plane);
				assert (got_top == want_top) else begin
					$display("CHECK FAILED rgb1 row %0d plane %0d column %0d: got %h expected %h",
						exp_row, exp_plane, c, got_top, want_top);
					note_content_error();
				end
				assert (got_bottom == want_bottom) else begin
					$display("CHECK FAILED rgb2 row %0d plane %0d column %0d: got %h expected %h",
						exp_row, exp_plane, c, got_bottom, want_bottom);
					note_content_error();
				end
			end
		end
		shown_plane = exp_plane;
		// planes 0 to 4 within a row, rows 0 to 15 within a frame
		if (exp_plane == `LM_PLANES - 1) begin
			exp_plane = 0;
			if (exp_row == `LM_ROWS - 1) begin
				exp_row = 0;
				frame_count++;
			end else begin
				exp_row++;
			end
		end else begin
			exp_plane++;
		end
		shift_count = 0;
	endtask

	// receiver and monitors, sampled mid cycle where outputs are settled
	always @(negedge clk_in) begin
		if (reset) begin
			shift_count = 0;
			clk_gap = 0;
			oe_cycles = 0;
			exp_row = 0;
			exp_plane = 0;
			shown_plane = 0;
		end else begin
			// four phase handshake, model follows each accepted write
			if (write_ack && !prev_ack) begin
				assert (prev_req) else begin
					$display("write_ack rose while write_req was low");
					err_handshake++;
				end
				model[write.addr] = write.data;
			end
			if (!write_ack && prev_ack) begin
				assert (!prev_req) else begin
					$display("write_ack fell while write_req was still high");
					err_handshake++;
				end
			end
			clk_gap++;
			if (panel_clk && !prev_clk) begin
				// steady column pace, no stall allowed within a row
				if (shift_count > 0) begin
					assert (clk_gap == COLUMN_PERIOD) else begin
						$display("panel_clk stalled, %0d cycles between shift clocks", clk_gap);
						err_live++;
					end
				end
				red1 = {red1[`LM_COLUMNS-2:0], rgb1[2]};
				green1 = {green1[`LM_COLUMNS-2:0], rgb1[1]};
				blue1 = {blue1[`LM_COLUMNS-2:0], rgb1[0]};
				red2 = {red2[`LM_COLUMNS-2:0], rgb2[2]};
				green2 = {green2[`LM_COLUMNS-2:0], rgb2[1]};
				blue2 = {blue2[`LM_COLUMNS-2:0], rgb2[0]};
				shift_count++;
				clk_gap = 0;
			end
			if (panel_latch && !prev_latch) begin
				latch_row();
			end
			if (!panel_oe) begin
				oe_cycles++;
				assert (panel_row == prev_row) else begin
					$display("panel_row changed while panel_oe was low");
					err_order++;
				end
			end else if (!prev_oe) begin
				// display interval just ended
				assert (oe_cycles == (`LM_OE_BASE << shown_plane)) else begin
					$display("CHECK FAILED panel_oe low cycles: got %h expected %h",
						oe_cycles, `LM_OE_BASE << shown_plane);
					err_timing++;
				end
				oe_cycles = 0;
			end
		end
		prev_clk = panel_clk;
		prev_latch = panel_latch;
		prev_oe = panel_oe;
		prev_req = write_req;
		prev_ack = write_ack;
		prev_row = panel_row;
	end

	task automatic check_idle_outputs(input string phase);
		assert (panel_oe === 1'b1) else begin
			$display("CHECK FAILED panel_oe %s: got %h expected %h", phase, panel_oe, 1'b1);
			err_reset++;
		end
		assert (panel_latch === 1'b0) else begin
			$display("CHECK FAILED panel_latch %s: got %h expected %h", phase, panel_latch, 1'b0);
			err_reset++;
		end
		assert (write_ack === 1'b0) else begin
			$display("CHECK FAILED write_ack %s: got %h expected %h", phase, write_ack, 1'b0);
			err_reset++;
		end
	endtask

	// one host write, called 5 ns after a rising edge
	task automatic host_write(input fb_write_t w);
		int n;
		write = w;
		write_req = 1'b1;
		n = 0;
		while (!write_ack && n < ACK_TIMEOUT) begin
			@(posedge clk_in);
			#5;
			n++;
		end
		assert (write_ack) else begin
			$display("write_ack did not rise within %0d cycles of write_req", ACK_TIMEOUT);
			err_handshake++;
		end
		write_req = 1'b0;
		n = 0;
		while (write_ack && n < ACK_TIMEOUT) begin
			@(posedge clk_in);
			#5;
			n++;
		end
		assert (!write_ack) else begin
			$display("write_ack did not fall within %0d cycles of dropping write_req", ACK_TIMEOUT);
			err_handshake++;
		end
	endtask

	task automatic report_test(input string name, input int errors);
		tests_run++;
		if (errors != 0) begin
			tests_failed++;
		end
		$display("test %0d %s: %s, %0d errors", tests_run, name,
			(errors == 0) ? "pass" : "FAIL", errors);
	endtask

	task automatic wait_frames(input int count);
		int start;
		start = frame_count;
		wait (frame_count - start >= count);
	endtask

	// watchdog sized from the frame length
	initial begin
		longint limit_ns;
		limit_ns = (FRAMES_USED * frame_cycles() + MARGIN_CYCLES) * CLK_PERIOD;
		#(limit_ns);
		$display("watchdog expired after %0d ns, the scan or a write handshake stopped", limit_ns);
		$display("Test failures found");
		$finish;
	end

	initial begin
		fb_write_t w;
		fb_addr_t live_addr;
		rgb565_t live_data;
		int i;
		int error_total;
		seed = 32'h7df4;
		clk_in = 1'b0;
		reset = 1'b1;
		write_req = 1'b0;
		write = '0;
		err_reset = 0;
		err_handshake = 0;
		err_content = 0;
		err_order = 0;
		err_timing = 0;
		err_live = 0;
		tests_run = 0;
		tests_failed = 0;
		compare_en = 1'b0;
		live_phase = 1'b0;
		frame_count = 0;
		// RAM powers up black
		for (i = 0; i < FB_WORDS; i++) begin
			model[i] = '0;
		end

		repeat (8) begin
			@(posedge clk_in);
			#5;
			check_idle_outputs("during reset");
		end
		reset = 1'b0;
		repeat (4) begin
			@(posedge clk_in);
			#5;
			check_idle_outputs("after reset");
		end
		report_test("reset state", err_reset);

		for (i = 0; i < WRITE_COUNT; i++) begin
			w.addr = fb_addr_t'($random(seed));
			w.data = rgb565_t'($random(seed));
			host_write(w);
		end
		report_test("write handshake", err_handshake);

		// compare one whole frame that starts after the writes
		wait_frames(1);
		compare_en = 1'b1;
		wait_frames(1);
		compare_en = 1'b0;
		report_test("shifted row content", err_content);
		report_test("row and plane order", err_order);
		report_test("modulation time", err_timing);

		// write into row 2 while row 4 is shifting, so mid frame and mid shift
		live_phase = 1'b1;
		wait (exp_row == 4 && shift_count > 0);
		@(posedge clk_in);
		#5;
		live_addr = {1'($random(seed)), row_t'(2), column_t'($random(seed))};
		live_data = ~model[live_addr];
		host_write({live_addr, live_data});
		assert (model[live_addr] == live_data) else begin
			$display("live write to address %h was not acknowledged", live_addr);
			err_live++;
		end
		wait_frames(1);
		compare_en = 1'b1;
		wait_frames(2);
		compare_en = 1'b0;
		report_test("live update", err_live);

		error_total = err_reset + err_handshake + err_content + err_order + err_timing + err_live;
		$display("tests run %0d, passed %0d, failed %0d, errors %0d",
			tests_run, tests_run - tests_failed, tests_failed, error_total);
		if (error_total == 0 && tests_failed == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
led_matrix_pkg.sv
countdown_timer.sv
framebuffer_ram.sv
framebuffer_fetch.sv
matrix_scan.sv
led_matrix_top.sv
tb_led_matrix.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the LED matrix testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
	--top-module tb_led_matrix -Mdir obj_dir -o sim_led_matrix -f list.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_led_matrix > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "Test failures found" "$LOG"; then
	echo "simulation reported failures"
	exit 1
fi

echo "simulation clean"
exit 0
